// File: Makefile
# Verilator build and run of the memory-access subsystem testbench

VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/memPkg.sv
logic/dataBusIf.sv
logic/memoryStage.sv
logic/addrTranslate.sv
logic/memSubsystem.sv
testbench/memChecker.sv
testbench/tbTop.sv

// File: logic/addrTranslate.sv
`timescale 1ns/1ps

module addrTranslate
    import memPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  satp_t      satp,
    dataBusIf.xlate    virt,
    output logic       busValid,
    output word_t      busAddr,
    output memSize_t   busSize,
    output logic [7:0] busStrobe,
    output word_t      busWData,
    input  logic       busAddrOk,
    input  logic       busDataOk,
    input  word_t      busRData
);

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        ACCESS
    } walkState_t;

    walkState_t  state;
    logic [1:0]  level;       // current sv39 level, 2 is the root
    word_t       tableBase;
    word_t       physAddr;    // final translated address
    word_t       walkAddr;
    word_t       leafAddr;
    logic [8:0]  vpnSel;
    logic [43:0] ptePpn;
    logic        busDone;
    logic        pteLeaf;
    logic        permOk;
    logic        walkFault;

    assign busDone = busAddrOk & busDataOk;
    assign ptePpn  = busRData[PTE_PPN_LSB +: 44];
    assign pteLeaf = busRData[PTE_R] | busRData[PTE_X];
    assign permOk  = virt.isWrite ? busRData[PTE_W] : busRData[PTE_R];

    // invalid entry, bad permission, or a pointer past the last level
    assign walkFault = ~busRData[PTE_V] | (pteLeaf & ~permOk) | (~pteLeaf & level == 2'd0);

    assign vpnSel   = virt.addr[PAGE_SHIFT + VPN_BITS * level +: VPN_BITS];
    assign walkAddr = tableBase + {52'b0, vpnSel, 3'b000};

    // superpages keep the lower vpn fields of the virtual address
    always_comb begin
        case (level)
            2'd2:    leafAddr = {8'b0, ptePpn[43:2*VPN_BITS],
                                 virt.addr[PAGE_SHIFT+2*VPN_BITS-1:0]};
            2'd1:    leafAddr = {8'b0, ptePpn[43:VPN_BITS],
                                 virt.addr[PAGE_SHIFT+VPN_BITS-1:0]};
            default: leafAddr = {8'b0, ptePpn, virt.addr[PAGE_SHIFT-1:0]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            level <= 2'(PAGE_LEVELS - 1);
        end else begin
            case (state)
                IDLE: if (satp.mode && virt.valid) begin
                    state <= WALK;
                    level <= 2'(PAGE_LEVELS - 1);
                end
                WALK: if (busDone) begin
                    if (walkFault) state <= IDLE;
                    else if (pteLeaf) state <= ACCESS;
                    else level <= level - 2'd1;   // descend one level
                end
                ACCESS: if (busDone) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) tableBase <= {8'b0, satp.ppn, 12'b0};
        else if (state == WALK && busDone && !pteLeaf) tableBase <= {8'b0, ptePpn, 12'b0};
        if (state == WALK && busDone && pteLeaf) physAddr <= leafAddr;
    end

    always_comb begin
        busValid    = 1'b0;
        busAddr     = '0;
        busSize     = MSIZE8;
        busStrobe   = 8'h00;
        busWData    = '0;
        virt.addrOk = 1'b0;
        virt.dataOk = 1'b0;
        virt.rdata  = busRData;
        virt.fault  = 1'b0;
        if (!satp.mode) begin
            // bare mode, straight through
            busValid    = virt.valid;
            busAddr     = virt.addr;
            busSize     = virt.size;
            busStrobe   = virt.strobe;
            busWData    = virt.data;
            virt.addrOk = busAddrOk;
            virt.dataOk = busDataOk;
        end else begin
            case (state)
                WALK: begin
                    busValid = 1'b1;
                    busAddr  = walkAddr;       // 8-byte pte read
                    if (busDone && walkFault) begin
                        virt.addrOk = 1'b1;
                        virt.dataOk = 1'b1;
                        virt.fault  = 1'b1;
                    end
                end
                ACCESS: begin
                    busValid    = 1'b1;
                    busAddr     = physAddr;
                    busSize     = virt.size;
                    busStrobe   = virt.strobe;
                    busWData    = virt.data;
                    virt.addrOk = busAddrOk;
                    virt.dataOk = busDataOk;
                end
                default: ;
            endcase
        end
    end

    busAddrStable: assert property (@(posedge clk) disable iff (reset)
        busValid && !(busAddrOk && busDataOk) |=> busValid && $stable(busAddr))
        else $error("busAddr changed while waiting for acceptance");

endmodule

// File: logic/dataBusIf.sv
`timescale 1ns/1ps

interface dataBusIf
    import memPkg::*;
();

    // request, from the stage
    logic       valid;
    word_t      addr;
    memSize_t   size;
    logic [7:0] strobe;   // zero for loads
    word_t      data;
    logic       isWrite;

    // response, from the translator
    logic       addrOk;
    logic       dataOk;
    word_t      rdata;
    logic       fault;    // only meaningful in the completion cycle

    modport stage (output valid, addr, size, strobe, data, isWrite,
                   input  addrOk, dataOk, rdata, fault);

    modport xlate (input  valid, addr, size, strobe, data, isWrite,
                   output addrOk, dataOk, rdata, fault);

endinterface

// File: logic/memPkg.sv
package memPkg;

    typedef logic [63:0] word_t;

    // access size, log2 of the byte count
    typedef enum logic [1:0] {
        MSIZE1 = 2'b00,
        MSIZE2 = 2'b01,
        MSIZE4 = 2'b10,
        MSIZE8 = 2'b11
    } memSize_t;

    typedef struct packed {
        logic     memRead;
        logic     memWrite;
        memSize_t memSize;
        logic     zeroExt;   // lbu, lhu, lwu
        logic     regWrite;
        logic     csrSrc;    // writeback takes the csr value
    } memCtl_t;

    // execute result as seen by the memory stage
    typedef struct packed {
        word_t      pc;
        word_t      aluOut;  // address for loads and stores
        word_t      storeData;
        word_t      csrData;
        logic [4:0] dst;
        memCtl_t    ctl;
    } execData_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] code;
        word_t      tval;
    } excep_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [4:0] dst;
        logic       regWrite;
        word_t      writeData;
        word_t      memAddr;
        excep_t     excep;
    } memData_t;

    typedef struct packed {
        logic        mode;   // 1 selects sv39, 0 is bare
        logic [43:0] ppn;
    } satp_t;

    localparam logic [3:0] EXC_LOAD_PAGE_FAULT  = 4'd13;
    localparam logic [3:0] EXC_STORE_PAGE_FAULT = 4'd15;

    // pte flags and ppn position
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_PPN_LSB = 10;

    localparam int PAGE_LEVELS = 3;
    localparam int PAGE_SHIFT  = 12;  // 4 KiB base page
    localparam int VPN_BITS    = 9;

endpackage

// File: logic/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem
    import memPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  satp_t      satp,
    input  execData_t  dataE,
    output memData_t   dataM,
    output logic       stall,

    // external data bus, physical side
    output logic       busValid,
    output word_t      busAddr,
    output memSize_t   busSize,
    output logic [7:0] busStrobe,
    output word_t      busWData,
    input  logic       busAddrOk,
    input  logic       busDataOk,
    input  word_t      busRData
);

    dataBusIf virtBus ();   // virtual-side request between stage and translator

    memoryStage u_stage (
        .clk   (clk),
        .reset (reset),
        .dataE (dataE),
        .dataM (dataM),
        .stall (stall),
        .bus   (virtBus.stage)
    );

    addrTranslate u_xlate (
        .clk       (clk),
        .reset     (reset),
        .satp      (satp),
        .virt      (virtBus.xlate),
        .busValid  (busValid),
        .busAddr   (busAddr),
        .busSize   (busSize),
        .busStrobe (busStrobe),
        .busWData  (busWData),
        .busAddrOk (busAddrOk),
        .busDataOk (busDataOk),
        .busRData  (busRData)
    );

endmodule

// File: logic/memoryStage.sv
`timescale 1ns/1ps

module memoryStage
    import memPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  execData_t dataE,
    output memData_t  dataM,
    output logic      stall,
    dataBusIf.stage   bus
);

    logic       isMem;
    logic       busDone;
    logic       faulted;
    logic [2:0] offset;
    logic [5:0] shiftBits;
    logic [7:0] sizeMask;
    word_t      loadShifted;
    word_t      loadValue;
    word_t      resultValue;

    // registered request
    logic       reqValid;
    word_t      reqAddr;
    memSize_t   reqSize;
    logic [7:0] reqStrobe;
    word_t      reqData;
    logic       reqWrite;

    assign isMem     = dataE.ctl.memRead | dataE.ctl.memWrite;
    assign offset    = dataE.aluOut[2:0];
    assign shiftBits = {offset, 3'b000};       // byte offset in bits
    assign busDone   = reqValid & bus.addrOk & bus.dataOk;
    assign faulted   = busDone & bus.fault;
    assign stall     = isMem & ~busDone;

    always_comb begin
        case (dataE.ctl.memSize)
            MSIZE1:  sizeMask = 8'h01;
            MSIZE2:  sizeMask = 8'h03;
            MSIZE4:  sizeMask = 8'h0f;
            default: sizeMask = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reqValid <= 1'b0;
        end else if (busDone) begin
            reqValid <= 1'b0;                    // drop after completion
        end else if (isMem & ~reqValid) begin
            reqValid <= 1'b1;
        end
    end

    // payload captured together with the valid rise
    always_ff @(posedge clk) begin
        if (isMem & ~reqValid) begin
            reqAddr   <= dataE.aluOut;
            reqSize   <= dataE.ctl.memSize;
            reqWrite  <= dataE.ctl.memWrite;
            reqData   <= dataE.ctl.memWrite ? dataE.storeData << shiftBits : '0;
            reqStrobe <= dataE.ctl.memWrite ? sizeMask << offset : 8'h00;
        end
    end

    assign bus.valid   = reqValid;
    assign bus.addr    = reqAddr;
    assign bus.size    = reqSize;
    assign bus.strobe  = reqStrobe;
    assign bus.data    = reqData;
    assign bus.isWrite = reqWrite;

    // align the bus word, then extend to 64 bits
    always_comb begin
        loadShifted = bus.rdata >> shiftBits;
        case (dataE.ctl.memSize)
            MSIZE1:  loadValue = dataE.ctl.zeroExt ? {56'b0, loadShifted[7:0]}
                                                   : {{56{loadShifted[7]}}, loadShifted[7:0]};
            MSIZE2:  loadValue = dataE.ctl.zeroExt ? {48'b0, loadShifted[15:0]}
                                                   : {{48{loadShifted[15]}}, loadShifted[15:0]};
            MSIZE4:  loadValue = dataE.ctl.zeroExt ? {32'b0, loadShifted[31:0]}
                                                   : {{32{loadShifted[31]}}, loadShifted[31:0]};
            default: loadValue = loadShifted;
        endcase
    end

    always_comb begin
        if (dataE.ctl.csrSrc) resultValue = dataE.csrData;
        else if (dataE.ctl.memRead) resultValue = loadValue;
        else resultValue = dataE.aluOut;

        dataM.valid    = 1'b1;
        dataM.pc       = dataE.pc;
        dataM.dst      = dataE.dst;
        dataM.regWrite = dataE.ctl.regWrite;
        dataM.memAddr  = isMem ? dataE.aluOut : '0;
        dataM.writeData = (dataE.ctl.regWrite && dataE.dst != 5'd0 && !faulted) ? resultValue
                                                                                 : '0;
        dataM.excep.valid = faulted;
        dataM.excep.code  = '0;
        dataM.excep.tval  = '0;
        if (faulted) begin
            dataM.excep.code = dataE.ctl.memWrite ? EXC_STORE_PAGE_FAULT : EXC_LOAD_PAGE_FAULT;
            dataM.excep.tval = dataE.aluOut;
        end
    end

    onlyOneAccess: assert property (@(posedge clk) disable iff (reset)
        !(dataE.ctl.memRead && dataE.ctl.memWrite))
        else $error("memRead and memWrite both set");

    // load alignment reads dataE directly, so it must hold through the access
    inputHeld: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(dataE))
        else $error("dataE changed while the stage was stalled");

endmodule

// File: testbench/memChecker.sv
`timescale 1ns/1ps

module memChecker
    import memPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  satp_t      satp,
    input  execData_t  dataE,
    input  memData_t   dataM,
    input  logic       stall,
    input  logic       busValid,
    input  word_t      busAddr,
    input  memSize_t   busSize,
    input  logic [7:0] busStrobe,
    input  word_t      busWData,
    input  logic       busAddrOk,
    input  logic       busDataOk,
    output int         tests,
    output int         errors
);

    word_t refMem [512];   // same image as the bus memory, updated by the model
    logic  waiting;        // request seen and not yet accepted
    word_t heldAddr;
    logic  wroteBus;
    int    stallCycles;

    initial begin
        tests       = 0;
        errors      = 0;
        waiting     = 1'b0;
        wroteBus    = 1'b0;
        stallCycles = 0;
    end

    task automatic compareValue(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic noteProblem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // keep the low size bytes, then sign or zero extend
    function automatic word_t extend(input word_t raw, input memSize_t size, input logic zext);
        int    bits;
        word_t mask;
        word_t val;
        bits = 8 << size;
        mask = (bits == 64) ? '1 : (64'd1 << bits) - 64'd1;
        val  = raw & mask;
        if (!zext && bits < 64 && val[bits - 1]) val = val | ~mask;
        return val;
    endfunction

    // sv39 walk over the model memory, returns 1 on a page fault
    function automatic logic translate(input word_t va, input logic isStore, output word_t pa);
        word_t base;
        word_t pteAddr;
        word_t pte;
        word_t keep;
        logic  found;
        logic  fault;
        int    lvl;
        pa    = va;
        base  = {8'b0, satp.ppn, 12'b0};
        found = 1'b0;
        fault = 1'b1;   // also the result when no leaf shows up
        for (lvl = 2; lvl >= 0; lvl--) begin
            if (!found) begin
                pteAddr = base + {52'b0, va[12 + 9 * lvl +: 9], 3'b000};
                pte     = refMem[pteAddr[11:3]];
                if (!pte[0]) begin
                    found = 1'b1;
                end else if (pte[1] || pte[3]) begin
                    found = 1'b1;
                    fault = isStore ? !pte[2] : !pte[1];
                    keep  = (64'd1 << (12 + 9 * lvl)) - 64'd1;   // offset and lower vpns
                    pa    = ({8'b0, pte[53:10], 12'b0} & ~keep) | (va & keep);
                end else begin
                    base = {8'b0, pte[53:10], 12'b0};
                end
            end
        end
        return fault;
    endfunction

    task automatic scoreInstruction();
        word_t pa;
        word_t expWrite;
        word_t loadVal;
        word_t laneMask;
        word_t expData;
        logic  fault;
        logic  isMem;
        int    off;
        int    nBytes;
        int    errsBefore;
        string kind;
        errsBefore = errors;
        isMem      = dataE.ctl.memRead || dataE.ctl.memWrite;
        off        = int'(dataE.aluOut[2:0]);
        nBytes     = 1 << dataE.ctl.memSize;
        pa         = dataE.aluOut;
        fault      = 1'b0;
        laneMask   = '0;
        expData    = '0;
        if (isMem && satp.mode) fault = translate(dataE.aluOut, dataE.ctl.memWrite, pa);
        loadVal  = extend(refMem[pa[11:3]] >> (8 * off), dataE.ctl.memSize, dataE.ctl.zeroExt);
        expWrite = dataE.ctl.csrSrc ? dataE.csrData
                                    : (dataE.ctl.memRead ? loadVal : dataE.aluOut);
        if (!dataE.ctl.regWrite || dataE.dst == 5'd0 || fault) expWrite = '0;
        compareValue("writeData", dataM.writeData, expWrite);
        compareValue("memAddr", dataM.memAddr, isMem ? dataE.aluOut : '0);
        compareValue("pc", dataM.pc, dataE.pc);
        compareValue("dst", 64'(dataM.dst), 64'(dataE.dst));
        compareValue("regWrite", 64'(dataM.regWrite), 64'(dataE.ctl.regWrite));
        compareValue("valid", 64'(dataM.valid), 64'd1);
        compareValue("excep.valid", 64'(dataM.excep.valid), 64'(fault));
        if (isMem ? stallCycles < 2 : stallCycles != 0) begin
            noteProblem($sformatf("stall was high for %0d cycles", stallCycles));
        end
        if (fault) begin
            compareValue("excep.code", 64'(dataM.excep.code),
                         dataE.ctl.memWrite ? 64'd15 : 64'd13);
            compareValue("excep.tval", dataM.excep.tval, dataE.aluOut);
            if (wroteBus) noteProblem("a faulting access still wrote to memory");
        end else if (isMem) begin
            compareValue("busAddr", busAddr, pa);
            compareValue("busSize", 64'(busSize), 64'(dataE.ctl.memSize));
            compareValue("busStrobe", 64'(busStrobe),
                         dataE.ctl.memWrite ? word_t'(((1 << nBytes) - 1) << off) : '0);
            if (dataE.ctl.memWrite) begin
                for (int b = 0; b < nBytes; b++) begin
                    laneMask[(off + b) * 8 +: 8] = 8'hff;
                    expData[(off + b) * 8 +: 8]  = dataE.storeData[b * 8 +: 8];
                    refMem[pa[11:3]][(off + b) * 8 +: 8] = dataE.storeData[b * 8 +: 8];
                end
                compareValue("busWData", busWData & laneMask, expData);   // strobed lanes only
            end
        end
        if (fault) kind = "page fault";
        else if (dataE.ctl.memRead) kind = "load";
        else if (dataE.ctl.memWrite) kind = "store";
        else kind = "alu";
        $display("test %0d %s at %h %s", tests, kind, dataE.aluOut,
                 (errors == errsBefore) ? "passed" : "failed");
        tests++;
    endtask

    // sampled mid-cycle, all inputs settled
    always @(negedge clk) begin
        if (reset) begin
            if (busValid !== 1'b0) noteProblem("busValid is not low during reset");
            waiting     = 1'b0;
            wroteBus    = 1'b0;
            stallCycles = 0;
        end else begin
            if (waiting) begin
                if (!busValid) noteProblem("busValid dropped before the transfer was accepted");
                compareValue("busAddr", busAddr, heldAddr);   // held while waiting
            end
            waiting  = busValid && !(busAddrOk && busDataOk);
            heldAddr = busAddr;
            if (busValid && busAddrOk && busDataOk && busStrobe != 8'h00) wroteBus = 1'b1;
            if (stall) begin
                stallCycles++;
            end else begin
                scoreInstruction();
                wroteBus    = 1'b0;
                stallCycles = 0;
            end
        end
    end

endmodule

// File: testbench/tbTop.sv
`timescale 1ns/1ps

module tbTop
    import memPkg::*;
();

    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 * 5 + 100;  // 4 bus transfers of 5 cycles each

    logic       clk;
    logic       reset;
    satp_t      satp;
    execData_t  dataE;
    memData_t   dataM;
    logic       stall;
    logic       busValid;
    word_t      busAddr;
    memSize_t   busSize;
    logic [7:0] busStrobe;
    word_t      busWData;
    logic       busAddrOk;
    logic       busDataOk;
    word_t      busRData;
    int         tests;
    int         errors;

    word_t      busMem [512];   // 4 KiB, physical addresses alias into it
    integer     seed = 32'h32dd_7591;

    memSubsystem u_memSubsystem (.*);

    memChecker u_checker (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // fill pattern plus an sv39 table rooted at physical 0, data stays above 0x800
    task automatic loadPageTable();
        for (int i = 0; i < 512; i++) begin
            busMem[i] = (word_t'(i) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0123_4567_89ab_cdef;
        end
        busMem[1] = 64'h401;       // root, vpn2 1 points to the table at 0x1000
        busMem[2] = 64'h801;       // level 1, vpn1 2 points to the table at 0x2000
        busMem[4] = 64'h10_0007;   // level 1, vpn1 4 is a 2 MiB superpage at 0x400000
        busMem[3] = 64'h1407;      // level 0, vpn0 3 is a 4 KiB page at 0x5000
        busMem[5] = 64'h1803;      // read-only page at 0x6000
        busMem[6] = 64'h0;         // invalid entry
        for (int i = 0; i < 512; i++) u_checker.refMem[i] = busMem[i];
    endtask

    function automatic execData_t randomInstr(input logic sv39);
        execData_t d;
        int        kind;
        int        page;
        word_t     low;
        word_t     va;
        d             = '0;
        d.pc          = {32'h0, $random(seed)} & ~64'h3;
        d.storeData   = {$random(seed), $random(seed)};
        d.csrData     = {$random(seed), $random(seed)};
        d.dst         = 5'($random(seed));
        d.ctl.memSize = memSize_t'($random(seed) & 3);
        d.ctl.zeroExt = 1'($random(seed));
        kind          = $random(seed) & 7;
        page          = $random(seed) & 3;
        low           = {$random(seed), $random(seed)};
        if (!sv39) va = low | 64'h800;
        else if (page == 3) va = {25'b0, 9'd1, 9'd4, low[20:0] | 21'h800};
        else va = {25'b0, 9'd1, 9'd2, 9'(page == 0 ? 3 : page + 4), low[11:0] | 12'h800};
        d.aluOut = va & ~((64'd1 << d.ctl.memSize) - 64'd1);   // naturally aligned
        if (kind < 3) begin
            d.ctl.memRead  = 1'b1;
            d.ctl.regWrite = 1'b1;
        end else if (kind < 6) begin
            d.ctl.memWrite = 1'b1;
        end else begin
            d.aluOut       = low;
            d.ctl.regWrite = 1'b1;
            d.ctl.csrSrc   = (kind == 7);
            if (($random(seed) & 3) == 0) d.dst = 5'd0;
        end
        return d;
    endfunction

    // bus slave, ok only for a request already seen in the previous cycle
    initial begin : responder
        logic       done;
        logic       pending;
        word_t      addr;
        word_t      wdata;
        logic [7:0] strobe;
        int         addrWait;
        int         dataWait;
        busAddrOk = 1'b0;
        busDataOk = 1'b0;
        busRData  = '0;
        addrWait  = 0;
        dataWait  = 0;
        forever begin
            @(negedge clk);   // request settled mid-cycle
            done    = busValid && busAddrOk && busDataOk;
            pending = busValid && !done && !reset;
            addr    = busAddr;
            strobe  = busStrobe;
            wdata   = busWData;
            @(posedge clk);
            if (done) begin
                for (int b = 0; b < 8; b++) begin
                    if (strobe[b]) busMem[addr[11:3]][b * 8 +: 8] = wdata[b * 8 +: 8];
                end
            end
            if (!pending) begin
                addrWait = $random(seed) & 3;
                dataWait = $random(seed) & 3;
            end
            #1;
            if (pending) begin
                if (addrWait == 0) busAddrOk = 1'b1;
                else addrWait--;
                if (dataWait == 0) busDataOk = 1'b1;
                else dataWait--;
                busRData = busMem[addr[11:3]];
            end else begin
                busAddrOk = 1'b0;
                busDataOk = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout reached after %0d cycles", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        reset = 1'b1;
        satp  = '0;
        dataE = '0;
        loadPageTable();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            if (n == NUM_INSTR / 2) satp.mode = 1'b1;   // second half goes through sv39
            dataE = randomInstr(satp.mode);
            do begin
                @(negedge clk);
            end while (stall);
            @(posedge clk);
            #1;
        end
        if (tests != NUM_INSTR) begin
            $display("checker counted %0d instructions instead of %0d", tests, NUM_INSTR);
        end
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0 && tests == NUM_INSTR) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
